// ==== Makefile ====
TOP = carry_prop_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== rtl/byte_buffer.sv ====
`timescale 1ns/1ps

module byte_buffer import carry_prop_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [SYM_WIDTH-1:0]  in_data,
  input  logic                  in_first,
  output logic [BYTE_WIDTH-1:0] out_data,
  buf_ctrl_if.buffer            buf_io
);

  logic                  carry_q;
  logic                  first_q;
  logic [BYTE_WIDTH-1:0] sym_byte_q;
  logic [BYTE_WIDTH-1:0] pend_q;
  logic [BYTE_WIDTH-1:0] base_byte;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // latched symbol flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // commit drops the carry so flush bytes come out unchanged
  always_ff @(posedge clk) begin
    if (rst) begin
      carry_q <= 1'b0;
      first_q <= 1'b0;
    end else if (buf_io.capture) begin
      carry_q <= in_data[SYM_WIDTH-1];
      first_q <= in_first;
    end else if (buf_io.commit) begin
      carry_q <= 1'b0;
    end
  end

  // byte payload
  always_ff @(posedge clk) begin
    if (buf_io.capture) begin
      sym_byte_q <= in_data[BYTE_WIDTH-1:0];
    end
    if (buf_io.commit) begin
      pend_q <= sym_byte_q;
    end
  end

  assign buf_io.hold_sym  = !carry_q && (sym_byte_q == BYTE_MAX);
  assign buf_io.first_sym = first_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output byte
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // run bytes wrap from 0xFF to 0x00 when a carry arrives
  assign base_byte = buf_io.emit_run ? BYTE_MAX : pend_q;
  assign out_data  = base_byte + {{(BYTE_WIDTH-1){1'b0}}, carry_q};

endmodule

// ==== rtl/carry_prop_ctrl.sv ====
`timescale 1ns/1ps

module carry_prop_ctrl import carry_prop_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  logic     in_last,
  output logic     in_ready,
  output logic     out_valid,
  output logic     out_last,
  input  logic     out_ready,
  run_ctrl_if.ctrl run,
  buf_ctrl_if.ctrl buf_io
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        sym_loaded;
  logic        sym_loaded_nxt;
  logic        last_q;
  logic        accepting;
  logic        out_fire;
  logic        flushing;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign accepting = (state == EMPTY) || (state == IDLE);
  assign flushing  = (state == FLUSH_PEND) || (state == FLUSH_RUN);

  // a latched symbol blocks new input until it is decided
  assign in_ready  = accepting && !sym_loaded;
  assign out_valid = !accepting;
  assign out_fire  = out_valid && out_ready;
  assign out_last  = flushing && run.run_zero;

  assign buf_io.capture  = in_valid && in_ready;
  assign buf_io.emit_run = (state == EMIT_RUN) || (state == FLUSH_RUN);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_nxt      = state;
    sym_loaded_nxt = sym_loaded;
    run.incr       = 1'b0;
    run.decr       = 1'b0;
    run.clear      = 1'b0;
    buf_io.commit  = 1'b0;
    if (buf_io.capture) begin
      sym_loaded_nxt = 1'b1;
    end
    case (state)
      EMPTY, IDLE: begin
        if (sym_loaded) begin
          if (buf_io.first_sym || (state == EMPTY)) begin
            // frame start only makes the byte pending
            buf_io.commit  = 1'b1;
            run.clear      = 1'b1;
            sym_loaded_nxt = 1'b0;
            state_nxt      = last_q ? FLUSH_PEND : IDLE;
          end else if (buf_io.hold_sym) begin
            run.incr       = 1'b1;
            sym_loaded_nxt = 1'b0;
            state_nxt      = last_q ? FLUSH_PEND : IDLE;
          end else begin
            state_nxt = EMIT_PEND;
          end
        end
      end
      EMIT_PEND, EMIT_RUN: begin
        if (out_fire) begin
          if (run.run_zero) begin
            // whole run written so the symbol byte becomes pending
            buf_io.commit  = 1'b1;
            sym_loaded_nxt = 1'b0;
            state_nxt      = last_q ? FLUSH_PEND : IDLE;
          end else begin
            // count is one behind the bytes left in EMIT_RUN
            run.decr  = 1'b1;
            state_nxt = EMIT_RUN;
          end
        end
      end
      FLUSH_PEND, FLUSH_RUN: begin
        if (out_fire) begin
          if (run.run_zero) begin
            run.clear = 1'b1;
            state_nxt = EMPTY;
          end else begin
            run.decr  = 1'b1;
            state_nxt = FLUSH_RUN;
          end
        end
      end
      default: state_nxt = EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= EMPTY;
      sym_loaded <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      state      <= state_nxt;
      sym_loaded <= sym_loaded_nxt;
      if (buf_io.capture) begin
        last_q <= in_last;
      end
    end
  end

endmodule

// ==== rtl/carry_prop_if.sv ====
`timescale 1ns/1ps

// controller <-> run counter
interface run_ctrl_if #(
  parameter int COUNT_WIDTH = 8
);
  logic incr;
  logic decr;
  logic clear;
  logic run_zero;
  // current run length for observation
  logic [COUNT_WIDTH-1:0] count;

  modport ctrl (output incr, decr, clear, input run_zero);
  modport counter (input incr, decr, clear, output run_zero, count);
endinterface

// controller <-> byte buffer
interface buf_ctrl_if;
  logic capture;
  logic commit;
  logic emit_run;
  // decoded from the latched symbol
  logic hold_sym;
  logic first_sym;

  modport ctrl (output capture, commit, emit_run, input hold_sym, first_sym);
  modport buffer (input capture, commit, emit_run, output hold_sym, first_sym);
endinterface

// ==== rtl/carry_prop_pkg.sv ====
package carry_prop_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stream widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int BYTE_WIDTH = 8;
  // carry sits in the top bit of a symbol
  localparam int SYM_WIDTH = BYTE_WIDTH + 1;

  // all-ones byte that a carry can ripple through
  localparam logic [BYTE_WIDTH-1:0] BYTE_MAX = '1;

  // controller states
  typedef enum logic [2:0] {
    EMPTY      = 3'd0,
    IDLE       = 3'd1,
    EMIT_PEND  = 3'd2,
    EMIT_RUN   = 3'd3,
    FLUSH_PEND = 3'd4,
    FLUSH_RUN  = 3'd5
  } ctrl_state_t;

endpackage

// ==== rtl/carry_prop_top.sv ====
`timescale 1ns/1ps

module carry_prop_top import carry_prop_pkg::*; #(
  parameter int COUNT_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  // symbol stream in
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [SYM_WIDTH-1:0]  in_data,
  input  logic                  in_first,
  input  logic                  in_last,
  // byte stream out
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [BYTE_WIDTH-1:0] out_data,
  output logic                  out_last
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // internal links
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  run_ctrl_if #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) run_if ();

  buf_ctrl_if buf_if ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // blocks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  carry_prop_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready),
    .run       (run_if),
    .buf_io    (buf_if)
  );

  run_counter #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_run_counter (
    .clk (clk),
    .rst (rst),
    .run (run_if)
  );

  // symbol bits only ever reach the buffer
  byte_buffer u_byte_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_first (in_first),
    .out_data (out_data),
    .buf_io   (buf_if)
  );

endmodule

// ==== rtl/run_counter.sv ====
`timescale 1ns/1ps

module run_counter #(
  parameter int COUNT_WIDTH = 8
) (
  input  logic        clk,
  input  logic        rst,
  run_ctrl_if.counter run
);

  logic [COUNT_WIDTH-1:0] count_q;

  // clear wins over incr and decr
  always_ff @(posedge clk) begin
    if (rst || run.clear) begin
      count_q <= '0;
    end else if (run.incr && !run.decr) begin
      count_q <= count_q + 1'b1;
    end else if (run.decr && !run.incr) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign run.count    = count_q;
  assign run.run_zero = (count_q == '0);

endmodule

// ==== sim/carry_prop_props.sv ====
`timescale 1ns/1ps

module carry_prop_props import carry_prop_pkg::*; #(
  parameter int COUNT_WIDTH = 8
) (
  input logic                   clk,
  input logic                   rst,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [BYTE_WIDTH-1:0]  out_data,
  input logic                   out_last,
  input ctrl_state_t            state,
  input logic                   incr,
  input logic                   decr,
  input logic                   clear,
  input logic [COUNT_WIDTH-1:0] count
);

  // bumped on every failing property
  int unsigned fail_count = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stream handshakes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else begin
      $error("output byte changed while stalled");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      $error("out_valid high right after reset");
      fail_count++;
    end

  // input side only opens once every output byte is gone
  one_side: assert property (@(posedge clk) disable iff (rst) !(in_ready && out_valid))
    else begin
      $error("in_ready and out_valid high together");
      fail_count++;
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // run counter range
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // no run may survive the end of a frame
  empty_no_run: assert property (@(posedge clk) disable iff (rst)
    state == EMPTY |-> count == '0)
    else begin
      $error("run count not zero while no frame is open");
      fail_count++;
    end

  no_wrap_up: assert property (@(posedge clk) disable iff (rst)
    incr && !decr && !clear |-> count != '1)
    else begin
      $error("run counter wrapped upward");
      fail_count++;
    end

  no_wrap_down: assert property (@(posedge clk) disable iff (rst)
    decr && !incr && !clear |-> count != '0)
    else begin
      $error("run counter wrapped below zero");
      fail_count++;
    end

endmodule

// ==== sim/carry_prop_tb.sv ====
`timescale 1ns/1ps

module carry_prop_tb import carry_prop_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int DRIVE_DELAY     = 1;
  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_FRAMES = 6;
  localparam int RAND_FRAMES     = 40;
  localparam int MAX_FRAME_LEN   = 24;
  localparam int WATCHDOG_CYCLES = (DIRECTED_FRAMES + RAND_FRAMES) * 400;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  in_valid;
  logic                  in_ready;
  logic [SYM_WIDTH-1:0]  in_data;
  logic                  in_first;
  logic                  in_last;
  logic                  out_valid;
  logic                  out_ready;
  logic [BYTE_WIDTH-1:0] out_data;
  logic                  out_last;

  integer seed = 32'h83ea_b1c3;

  // frame being built and the flat symbol stream with flags and idle gaps
  logic [SYM_WIDTH-1:0]  frame_syms[$];
  logic [SYM_WIDTH-1:0]  sym_q[$];
  bit                    first_q[$];
  bit                    last_q[$];
  int                    gap_q[$];
  // bytes the model expects in order
  logic [BYTE_WIDTH-1:0] exp_byte_q[$];
  bit                    exp_last_q[$];

  carry_prop_top #(
    .COUNT_WIDTH (8)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_first  (in_first),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

  bind carry_prop_top carry_prop_props #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_props (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .state     (u_ctrl.state),
    .incr      (run_if.incr),
    .decr      (run_if.decr),
    .clear     (run_if.clear),
    .count     (run_if.count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic push_expected(input logic [BYTE_WIDTH-1:0] b, input bit last);
    exp_byte_q.push_back(b);
    exp_last_q.push_back(last);
  endtask

  task automatic close_frame();
    logic [BYTE_WIDTH-1:0] pend;
    logic [BYTE_WIDTH-1:0] b;
    logic                  c;
    int                    run;
    int                    n;
    int                    gap;
    n = frame_syms.size();
    foreach (frame_syms[i]) begin
      gap = 0;
      if ($unsigned($random(seed)) % 4 == 0) begin
        gap = 1 + int'($unsigned($random(seed)) % 3);
      end
      sym_q.push_back(frame_syms[i]);
      first_q.push_back(i == 0);
      last_q.push_back(i == n - 1);
      gap_q.push_back(gap);
    end
    // first symbol only loads the pending byte
    pend = frame_syms[0][BYTE_WIDTH-1:0];
    run  = 0;
    for (int i = 1; i < n; i++) begin
      c = frame_syms[i][SYM_WIDTH-1];
      b = frame_syms[i][BYTE_WIDTH-1:0];
      if (!c && b == BYTE_MAX) begin
        run++;
      end else begin
        push_expected(pend + {{(BYTE_WIDTH-1){1'b0}}, c}, 1'b0);
        repeat (run) push_expected(c ? 8'h00 : BYTE_MAX, 1'b0);
        pend = b;
        run  = 0;
      end
    end
    // flush the pending byte and any open run
    push_expected(pend, run == 0);
    for (int k = 0; k < run; k++) begin
      push_expected(BYTE_MAX, k == run - 1);
    end
    frame_syms.delete();
  endtask

  task automatic random_frame();
    logic [BYTE_WIDTH-1:0] b;
    logic                  c;
    int                    len;
    len = 1 + int'($unsigned($random(seed)) % MAX_FRAME_LEN);
    repeat (len) begin
      b = 8'($random(seed));
      // about a third 0xFF so runs form
      if ($unsigned($random(seed)) % 3 == 0) begin
        b = BYTE_MAX;
      end
      c = ($unsigned($random(seed)) % 4) == 0;
      frame_syms.push_back({c, b});
    end
    close_frame();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic send_symbol(input int idx);
    repeat (gap_q[idx]) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in_valid = 1'b1;
    in_data  = sym_q[idx];
    in_first = first_q[idx];
    in_last  = last_q[idx];
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    #DRIVE_DELAY;
    out_ready = ($unsigned($random(seed)) % 3) != 0;
  end

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    in_first  = 1'b0;
    in_last   = 1'b0;
    out_ready = 1'b0;
    // plain bytes pass straight through
    frame_syms = '{9'h012, 9'h034, 9'h056, 9'h078};
    close_frame();
    // carry with no run bumps the byte before it
    frame_syms = '{9'h010, 9'h020, 9'h130};
    close_frame();
    // run closed without carry
    frame_syms = '{9'h040, 9'h0ff, 9'h0ff, 9'h050};
    close_frame();
    // run closed by a carry turns into 0x00 bytes
    frame_syms = '{9'h040, 9'h0ff, 9'h0ff, 9'h0ff, 9'h160};
    close_frame();
    // frame ends inside a run
    frame_syms = '{9'h070, 9'h0ff, 9'h0ff};
    close_frame();
    // single symbol frame whose carry is ignored
    frame_syms = '{9'h1ff};
    close_frame();
    repeat (RAND_FRAMES) random_frame();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    foreach (sym_q[i]) send_symbol(i);
    while (exp_byte_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    if (!out_valid && UUT.u_props.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // values at the falling edge are the ones taken at the next rising edge
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_byte_q.size() == 0) begin
        $display("output byte %02h at %0t ns when no byte was expected", out_data, $time);
        $display("tests failed");
        $fatal(1);
      end else begin
        assert (out_data == exp_byte_q[0]) else begin
          $display("FAIL at %0t ns: out_data expected %02h, got %02h",
                   $time, exp_byte_q[0], out_data);
          $display("tests failed");
          $fatal(1);
        end
        assert (out_last == exp_last_q[0]) else begin
          $display("FAIL at %0t ns: out_last expected %0b, got %0b",
                   $time, exp_last_q[0], out_last);
          $display("tests failed");
          $fatal(1);
        end
        void'(exp_byte_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (UUT.u_props.fail_count != 0) begin
      $display("a bound property on the DUT failed at %0t ns", $time);
      $display("tests failed");
      $fatal(1);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $fatal(1);
  end

endmodule

// ==== sources.f ====
rtl/carry_prop_pkg.sv
rtl/carry_prop_if.sv
rtl/carry_prop_ctrl.sv
rtl/run_counter.sv
rtl/byte_buffer.sv
rtl/carry_prop_top.sv
sim/carry_prop_props.sv
sim/carry_prop_tb.sv
